/* Bender.yml */
package:
  name: cpuCore

sources:
  - files:
      - hw/cpuPkg.sv
      - hw/pipeIf.sv
      - hw/controlUnit.sv
      - hw/hazardUnit.sv
      - hw/regFile.sv
      - hw/aluUnit.sv
      - hw/datapath.sv
      - hw/cpuTop.sv
  - target: test
    files:
      - tb/cpuChecker.sv
      - tb/cpuTb.sv

/* build.f */
hw/cpuPkg.sv
hw/pipeIf.sv
hw/controlUnit.sv
hw/hazardUnit.sv
hw/regFile.sv
hw/aluUnit.sv
hw/datapath.sv
hw/cpuTop.sv
tb/cpuChecker.sv
tb/cpuTb.sv

/* hw/aluUnit.sv */
module aluUnit import cpuPkg::*; (
    input  logic [wordWidth-1:0] a,
    input  logic [wordWidth-1:0] b,
    input  aluOp                 op,
    input  logic [3:0]           opcode,
    output logic [wordWidth-1:0] result,
    output logic                 branchTaken
);

    always_comb begin
        case (op)
            aluAdd:     result = a + b;
            aluSub:     result = a - b;
            aluAnd:     result = a & b;
            aluOr:      result = a | b;
            aluPassB:   result = b;
            // LHI puts the immediate in the upper byte
            aluShiftHi: result = {b[7:0], {(wordWidth-8){1'b0}}};
            default:    result = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            opBne:   branchTaken = (a != b);
            opBeq:   branchTaken = (a == b);
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

/* hw/controlUnit.sv */
module controlUnit import cpuPkg::*; (
    ctrlIf.dec dec
);

    instrWord instr;
    ctrlBits c;
    logic useRs;
    logic useRt;

    assign instr = dec.idInstr;

    always_comb begin
        c = '0;
        useRs = 1'b0;
        useRt = 1'b0;
        // a bubble keeps every control low
        if (dec.idValid) begin
            case (instr.iView.opcode)
                opAlu: begin
                    c.isAlu = 1'b1;
                    case (instr.rView.func)
                        fnAdd, fnSub, fnAnd, fnOrr: begin
                            c.regDst = 1'b1;
                            c.regWrite = 1'b1;
                            useRs = 1'b1;
                            useRt = 1'b1;
                        end
                        fnWwd: begin
                            c.wwd = 1'b1;
                            useRs = 1'b1;
                        end
                        fnJpr: begin
                            c.isJumpR = 1'b1;
                            useRs = 1'b1;
                        end
                        // HLT only needs to reach writeback
                        default: c.isAlu = 1'b0;
                    endcase
                end
                opAdi, opOri: begin
                    c.aluSrc = 1'b1;
                    c.regWrite = 1'b1;
                    useRs = 1'b1;
                end
                opLhi: begin
                    c.aluSrc = 1'b1;
                    c.regWrite = 1'b1;
                end
                opLwd: begin
                    c.aluSrc = 1'b1;
                    c.memRead = 1'b1;
                    c.memToReg = 1'b1;
                    c.regWrite = 1'b1;
                    useRs = 1'b1;
                end
                opSwd: begin
                    c.aluSrc = 1'b1;
                    c.memWrite = 1'b1;
                    useRs = 1'b1;
                    useRt = 1'b1;
                end
                opBne, opBeq: begin
                    c.isBranch = 1'b1;
                    useRs = 1'b1;
                    useRt = 1'b1;
                end
                opJmp: c.isJump = 1'b1;
                // link write goes to register 2
                opJal: begin
                    c.isJump = 1'b1;
                    c.regWrite = 1'b1;
                end
                default: c = '0;
            endcase
        end
    end

    assign dec.ctrl = c;
    assign dec.useRs = useRs;
    assign dec.useRt = useRt;

endmodule

/* hw/cpuPkg.sv */
package cpuPkg;

    localparam int wordWidth = 16;
    localparam int regAddrWidth = 2;

    // opcodes
    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opOri = 4'd5;
    localparam logic [3:0] opLhi = 4'd6;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [3:0] opJal = 4'd10;
    localparam logic [3:0] opAlu = 4'd15;

    // function codes under opAlu
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnJpr = 6'd25;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    typedef struct packed {
        logic [3:0] opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [5:0] func;
    } rFields;

    typedef struct packed {
        logic [3:0] opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [7:0] imm;
    } iFields;

    typedef struct packed {
        logic [3:0] opcode;
        logic [11:0] target;
    } jFields;

    // one instruction word, three ways to read it
    typedef union packed {
        rFields rView;
        iFields iView;
        jFields jView;
    } instrWord;

    typedef struct packed {
        logic regDst;
        logic isJump;
        logic isJumpR;
        logic isAlu;
        logic aluSrc;
        logic isBranch;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic regWrite;
        logic wwd;
    } ctrlBits;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluPassB,
        aluShiftHi
    } aluOp;

    typedef enum logic [1:0] {
        fromReg,
        fromMem,
        fromWb
    } fwdSel;

endpackage

/* hw/cpuTop.sv */
module cpuTop import cpuPkg::*; (
    input  logic                 Clk,
    input  logic                 reset,
    output logic                 readInstr,
    output logic [wordWidth-1:0] instrAddr,
    input  logic [wordWidth-1:0] instrIn,
    output logic                 readData,
    output logic                 writeData,
    output logic [wordWidth-1:0] dataAddr,
    input  logic [wordWidth-1:0] dataIn,
    output logic [wordWidth-1:0] dataOut,
    output logic [wordWidth-1:0] numInst,
    output logic [wordWidth-1:0] outputPort,
    output logic                 halted
);

    ctrlIf ctrlBus ();
    hazardIf hazBus ();

    controlUnit i_control (
        .dec (ctrlBus.dec)
    );

    hazardUnit i_hazard (
        .haz (hazBus.haz)
    );

    datapath i_datapath (
        .Clk        (Clk),
        .reset      (reset),
        .ctrl       (ctrlBus.pipe),
        .haz        (hazBus.pipe),
        .readInstr  (readInstr),
        .instrAddr  (instrAddr),
        .instrIn    (instrIn),
        .readData   (readData),
        .writeData  (writeData),
        .dataAddr   (dataAddr),
        .dataIn     (dataIn),
        .dataOut    (dataOut),
        .numInst    (numInst),
        .outputPort (outputPort),
        .halted     (halted)
    );

endmodule

/* hw/datapath.sv */
module datapath import cpuPkg::*; (
    input  logic                 Clk,
    input  logic                 reset,
    ctrlIf.pipe                  ctrl,
    hazardIf.pipe                haz,
    output logic                 readInstr,
    output logic [wordWidth-1:0] instrAddr,
    input  logic [wordWidth-1:0] instrIn,
    output logic                 readData,
    output logic                 writeData,
    output logic [wordWidth-1:0] dataAddr,
    input  logic [wordWidth-1:0] dataIn,
    output logic [wordWidth-1:0] dataOut,
    output logic [wordWidth-1:0] numInst,
    output logic [wordWidth-1:0] outputPort,
    output logic                 halted
);

    logic [wordWidth-1:0] pc;
    logic [wordWidth-1:0] pcPlusOne;
    logic [wordWidth-1:0] nextPc;

    // IF/ID
    instrWord ifIdInstr;
    logic [wordWidth-1:0] ifIdPc;
    logic ifIdBubble;

    // ID/EX
    instrWord exInstr;
    ctrlBits exCtrl;
    logic [wordWidth-1:0] exPc;
    logic [wordWidth-1:0] exData1;
    logic [wordWidth-1:0] exData2;
    logic [wordWidth-1:0] exImm;
    logic [regAddrWidth-1:0] exRd;
    logic exHlt;
    logic idExBubble;

    // EX/MEM
    ctrlBits memCtrl;
    logic [wordWidth-1:0] memAluOut;
    logic [wordWidth-1:0] memStoreData;
    logic [regAddrWidth-1:0] memRd;
    logic memHlt;
    logic exMemBubble;

    // MEM/WB
    ctrlBits wbCtrl;
    logic [wordWidth-1:0] wbAluOut;
    logic [wordWidth-1:0] wbLoadData;
    logic [regAddrWidth-1:0] wbRd;
    logic wbHlt;
    logic memWbBubble;

    // decode stage
    logic [regAddrWidth-1:0] idRd;
    logic [wordWidth-1:0] idImm;
    logic [wordWidth-1:0] idData1;
    logic [wordWidth-1:0] idData2;
    logic [wordWidth-1:0] jumpTarget;
    logic idHlt;
    logic takeJump;

    // execute stage
    logic [wordWidth-1:0] fwdAVal;
    logic [wordWidth-1:0] fwdBVal;
    logic [wordWidth-1:0] aluB;
    logic [wordWidth-1:0] aluResult;
    logic [wordWidth-1:0] branchTarget;
    aluOp exAluOp;
    logic exLink;
    logic branchTaken;
    logic takeBranch;
    logic takeJumpR;
    logic exRedirect;

    logic [wordWidth-1:0] wbWriteData;
    logic haltNow;

    assign readInstr = !halted;
    assign instrAddr = pc;
    assign pcPlusOne = pc + 1'b1;

    // decode
    assign ctrl.idInstr = ifIdInstr;
    assign ctrl.idValid = !ifIdBubble;

    always_comb begin
        if ((ctrl.ctrl.isJump || ctrl.ctrl.isJumpR) && ctrl.ctrl.regWrite) begin
            idRd = regAddrWidth'(2);
        end else if (ctrl.ctrl.regDst) begin
            idRd = ifIdInstr.rView.rd;
        end else begin
            idRd = ifIdInstr.iView.rt;
        end
    end

    // ORI takes its immediate zero extended
    assign idImm = (ifIdInstr.iView.opcode == opOri) ?
                   {{(wordWidth-8){1'b0}}, ifIdInstr.iView.imm} :
                   {{(wordWidth-8){ifIdInstr.iView.imm[7]}}, ifIdInstr.iView.imm};
    assign jumpTarget = {ifIdPc[wordWidth-1:12], ifIdInstr.jView.target};
    assign idHlt = !ifIdBubble && (ifIdInstr.rView.opcode == opAlu) &&
                   (ifIdInstr.rView.func == fnHlt);
    assign takeJump = ctrl.ctrl.isJump;

    regFile i_regFile (
        .Clk     (Clk),
        .reset   (reset),
        .rs      (ifIdInstr.rView.rs),
        .rt      (ifIdInstr.rView.rt),
        .wAddr   (wbRd),
        .wData   (wbWriteData),
        .wEnable (wbCtrl.regWrite),
        .rData1  (idData1),
        .rData2  (idData2)
    );

    assign haz.rs = ifIdInstr.rView.rs;
    assign haz.rt = ifIdInstr.rView.rt;
    assign haz.useRs = ctrl.useRs;
    assign haz.useRt = ctrl.useRt;
    assign haz.exRs = exInstr.rView.rs;
    assign haz.exRt = exInstr.rView.rt;
    assign haz.exRd = exRd;
    assign haz.exMemRead = exCtrl.memRead;
    assign haz.memRd = memRd;
    assign haz.memRegWrite = memCtrl.regWrite;
    assign haz.wbRd = wbRd;
    assign haz.wbRegWrite = wbCtrl.regWrite;

    // execute
    assign wbWriteData = wbCtrl.memToReg ? wbLoadData : wbAluOut;

    always_comb begin
        case (haz.fwdA)
            fromMem: fwdAVal = memAluOut;
            fromWb:  fwdAVal = wbWriteData;
            default: fwdAVal = exData1;
        endcase
        case (haz.fwdB)
            fromMem: fwdBVal = memAluOut;
            fromWb:  fwdBVal = wbWriteData;
            default: fwdBVal = exData2;
        endcase
    end

    // link instructions carry the return address through the ALU
    assign exLink = exCtrl.regWrite && (exCtrl.isJump || exCtrl.isJumpR);

    always_comb begin
        if (exLink) begin
            aluB = exPc;
        end else if (exCtrl.aluSrc) begin
            aluB = exImm;
        end else if (exCtrl.wwd) begin
            aluB = '0;
        end else begin
            aluB = fwdBVal;
        end
    end

    always_comb begin
        if (exLink) begin
            exAluOp = aluPassB;
        end else if (exCtrl.isAlu) begin
            case (exInstr.rView.func)
                fnSub:   exAluOp = aluSub;
                fnAnd:   exAluOp = aluAnd;
                fnOrr:   exAluOp = aluOr;
                default: exAluOp = aluAdd;
            endcase
        end else begin
            case (exInstr.iView.opcode)
                opOri:   exAluOp = aluOr;
                opLhi:   exAluOp = aluShiftHi;
                default: exAluOp = aluAdd;
            endcase
        end
    end

    aluUnit i_alu (
        .a           (fwdAVal),
        .b           (aluB),
        .op          (exAluOp),
        .opcode      (exInstr.iView.opcode),
        .result      (aluResult),
        .branchTaken (branchTaken)
    );

    assign branchTarget = exPc + exImm;
    assign takeBranch = !idExBubble && exCtrl.isBranch && branchTaken;
    assign takeJumpR = !idExBubble && exCtrl.isJumpR;
    assign exRedirect = takeBranch || takeJumpR;

    always_comb begin
        if (takeBranch) begin
            nextPc = branchTarget;
        end else if (takeJumpR) begin
            nextPc = fwdAVal;
        end else if (takeJump) begin
            nextPc = jumpTarget;
        end else if (haz.stall) begin
            nextPc = pc;
        end else begin
            nextPc = pcPlusOne;
        end
    end

    // memory
    assign haltNow = !memWbBubble && wbHlt;
    assign readData = memCtrl.memRead;
    // a store behind a retiring HLT must not land
    assign writeData = memCtrl.memWrite && !haltNow;
    assign dataAddr = memAluOut;
    assign dataOut = memStoreData;

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= '0;
            ifIdBubble <= 1'b1;
            idExBubble <= 1'b1;
            exMemBubble <= 1'b1;
            memWbBubble <= 1'b1;
            exCtrl <= '0;
            memCtrl <= '0;
            wbCtrl <= '0;
            exHlt <= 1'b0;
            memHlt <= 1'b0;
            wbHlt <= 1'b0;
        end else if (haltNow || halted) begin
            ifIdBubble <= 1'b1;
            idExBubble <= 1'b1;
            exMemBubble <= 1'b1;
            memWbBubble <= 1'b1;
            exCtrl <= '0;
            memCtrl <= '0;
            wbCtrl <= '0;
        end else begin
            pc <= nextPc;
            if (exRedirect || takeJump) begin
                ifIdBubble <= 1'b1;
            end else if (!haz.stall) begin
                ifIdBubble <= 1'b0;
            end
            idExBubble <= ifIdBubble || haz.stall || exRedirect;
            exCtrl <= (haz.stall || exRedirect) ? '0 : ctrl.ctrl;
            exHlt <= idHlt && !haz.stall && !exRedirect;
            exMemBubble <= idExBubble;
            memCtrl <= exCtrl;
            memHlt <= exHlt;
            memWbBubble <= exMemBubble;
            wbCtrl <= memCtrl;
            wbHlt <= memHlt;
        end
    end

    // payload, qualified by the bubble flags and controls above
    always_ff @(posedge Clk) begin
        if (!haz.stall) begin
            ifIdInstr <= instrIn;
            ifIdPc <= pcPlusOne;
        end
        exInstr <= ifIdInstr;
        exPc <= ifIdPc;
        exData1 <= idData1;
        exData2 <= idData2;
        exImm <= idImm;
        exRd <= idRd;
        memAluOut <= aluResult;
        memStoreData <= fwdBVal;
        memRd <= exRd;
        wbAluOut <= memAluOut;
        wbLoadData <= dataIn;
        wbRd <= memRd;
    end

    // retire
    always_ff @(posedge Clk) begin
        if (reset) begin
            numInst <= '0;
            outputPort <= '0;
            halted <= 1'b0;
        end else if (!memWbBubble) begin
            numInst <= numInst + 1'b1;
            if (wbCtrl.wwd) begin
                outputPort <= wbAluOut;
            end
            if (wbHlt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* hw/hazardUnit.sv */
module hazardUnit import cpuPkg::*; (
    hazardIf.haz haz
);

    logic rsHit;
    logic rtHit;

    // memory stage is the younger result, so it wins over writeback
    function automatic fwdSel pickSource(
        input logic [regAddrWidth-1:0] src,
        input logic [regAddrWidth-1:0] memRd,
        input logic memRegWrite,
        input logic [regAddrWidth-1:0] wbRd,
        input logic wbRegWrite
    );
        if (memRegWrite && (memRd == src)) begin
            return fromMem;
        end
        if (wbRegWrite && (wbRd == src)) begin
            return fromWb;
        end
        return fromReg;
    endfunction

    // load in execute feeding the instruction right behind it
    assign rsHit = haz.useRs && (haz.rs == haz.exRd);
    assign rtHit = haz.useRt && (haz.rt == haz.exRd);
    assign haz.stall = haz.exMemRead && (rsHit || rtHit);

    assign haz.fwdA = pickSource(haz.exRs, haz.memRd, haz.memRegWrite,
                                 haz.wbRd, haz.wbRegWrite);
    assign haz.fwdB = pickSource(haz.exRt, haz.memRd, haz.memRegWrite,
                                 haz.wbRd, haz.wbRegWrite);

endmodule

/* hw/pipeIf.sv */
interface ctrlIf import cpuPkg::*; ();
    instrWord idInstr;
    // low while the decode stage holds a bubble
    logic idValid;
    ctrlBits ctrl;
    logic useRs;
    logic useRt;

    modport dec (input idInstr, idValid, output ctrl, useRs, useRt);
    modport pipe (output idInstr, idValid, input ctrl, useRs, useRt);
endinterface

interface hazardIf import cpuPkg::*; ();
    // decode stage sources
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic useRs;
    logic useRt;
    // execute stage
    logic [regAddrWidth-1:0] exRs;
    logic [regAddrWidth-1:0] exRt;
    logic [regAddrWidth-1:0] exRd;
    logic exMemRead;
    // memory and writeback destinations
    logic [regAddrWidth-1:0] memRd;
    logic memRegWrite;
    logic [regAddrWidth-1:0] wbRd;
    logic wbRegWrite;
    // results
    logic stall;
    fwdSel fwdA;
    fwdSel fwdB;

    modport haz (
        input rs, rt, useRs, useRt, exRs, exRt, exRd, exMemRead,
        input memRd, memRegWrite, wbRd, wbRegWrite,
        output stall, fwdA, fwdB
    );
    modport pipe (
        output rs, rt, useRs, useRt, exRs, exRt, exRd, exMemRead,
        output memRd, memRegWrite, wbRd, wbRegWrite,
        input stall, fwdA, fwdB
    );
endinterface

/* hw/regFile.sv */
module regFile import cpuPkg::*; (
    input  logic                    Clk,
    input  logic                    reset,
    input  logic [regAddrWidth-1:0] rs,
    input  logic [regAddrWidth-1:0] rt,
    input  logic [regAddrWidth-1:0] wAddr,
    input  logic [wordWidth-1:0]    wData,
    input  logic                    wEnable,
    output logic [wordWidth-1:0]    rData1,
    output logic [wordWidth-1:0]    rData2
);

    logic [wordWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge Clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wEnable) begin
            regs[wAddr] <= wData;
        end
    end

    // writeback in the same cycle shows up on the read ports
    assign rData1 = (wEnable && (wAddr == rs)) ? wData : regs[rs];
    assign rData2 = (wEnable && (wAddr == rt)) ? wData : regs[rt];

endmodule

/* tb/cpuChecker.sv */
module cpuChecker (
    input  logic        Clk,
    input  logic        reset,
    input  logic        halted,
    input  logic        readInstr,
    input  logic        readData,
    input  logic        writeData,
    input  logic [15:0] outputPort,
    input  logic [15:0] numInst,
    output int          testCount,
    output int          failCount,
    output int          errCount
);

    int compareErrors;
    int watchErrors;
    int watchMark;
    int resetCycles;
    logic holding;
    logic [15:0] heldOut;
    string curName;

    initial begin
        testCount = 0;
        failCount = 0;
        compareErrors = 0;
        watchErrors = 0;
        watchMark = 0;
        resetCycles = 0;
        holding = 1'b0;
        heldOut = '0;
        curName = "none";
    end

    assign errCount = compareErrors + watchErrors;

    task automatic startTest(input string name);
        curName = name;
    endtask

    // reset has to clear the status, and a halted core has to stay put
    always @(negedge Clk) begin
        if (reset) begin
            holding = 1'b0;
            resetCycles = resetCycles + 1;
            if (resetCycles >= 2 && (halted !== 1'b0 || numInst !== 16'd0)) begin
                $display("%s: reset did not clear the core (numInst %0d, halted %b)",
                         curName, numInst, halted);
                watchErrors = watchErrors + 1;
            end
            if (resetCycles >= 2 &&
                (readInstr !== 1'b1 || readData !== 1'b0 || writeData !== 1'b0)) begin
                $display("%s: wrong strobes in reset (readInstr %b, readData %b, writeData %b)",
                         curName, readInstr, readData, writeData);
                watchErrors = watchErrors + 1;
            end
        end else begin
            resetCycles = 0;
            if (holding) begin
                if (halted !== 1'b1) begin
                    $display("%s: halted fell after HLT without a reset", curName);
                    watchErrors = watchErrors + 1;
                end
                if (readInstr !== 1'b0 || readData !== 1'b0 || writeData !== 1'b0) begin
                    $display("%s: memory strobes still active after HLT", curName);
                    watchErrors = watchErrors + 1;
                end
                if (outputPort !== heldOut) begin
                    $display("mismatch %s: outputPort after halt expected %h actual %h",
                             curName, heldOut, outputPort);
                    watchErrors = watchErrors + 1;
                end
            end else if (halted === 1'b1) begin
                holding = 1'b1;
                heldOut = outputPort;
            end
        end
    end

    task automatic checkTest(input logic [15:0] expOut, input logic [15:0] expNum);
        int bad;
        bad = 0;
        if (outputPort !== expOut) begin
            $display("mismatch %s: outputPort expected %h actual %h",
                     curName, expOut, outputPort);
            bad = bad + 1;
        end
        if (numInst !== expNum) begin
            $display("mismatch %s: numInst expected %0d actual %0d",
                     curName, expNum, numInst);
            bad = bad + 1;
        end
        compareErrors = compareErrors + bad;
        testCount = testCount + 1;
        if (bad == 0 && watchErrors == watchMark) begin
            $display("test %s passed: outputPort %h, numInst %0d",
                     curName, outputPort, numInst);
        end else begin
            failCount = failCount + 1;
            $display("test %s failed", curName);
        end
        watchMark = watchErrors;
    endtask

endmodule

/* tb/cpuTb.sv */
module cpuTb import cpuPkg::*; ();

    localparam int numTests = 6;
    localparam int progWords = 16;
    localparam int imemWords = 64;
    localparam int dmemWords = 256;
    localparam int cycleLimit = numTests * 200;
    localparam logic [15:0] haltWord = {opAlu, 6'd0, fnHlt};

    logic Clk;
    logic reset;
    logic readInstr;
    logic [15:0] instrAddr;
    logic [15:0] instrIn;
    logic readData;
    logic writeData;
    logic [15:0] dataAddr;
    logic [15:0] dataIn;
    logic [15:0] dataOut;
    logic [15:0] numInst;
    logic [15:0] outputPort;
    logic halted;

    int testCount;
    int failCount;
    int errCount;
    int seed;
    string curName;

    logic [15:0] instrMem [imemWords];
    logic [15:0] dataMem [dmemWords];
    logic [15:0] prefill [dmemWords];

    // program table
    string names [numTests];
    logic [15:0] progs [numTests][progWords];
    int progLen [numTests];
    logic [15:0] expOut [numTests];
    logic [15:0] expNum [numTests];
    // data address whose prefill value adds to expOut, or -1
    int loadAddr [numTests];

    cpuTop i_dut (
        .Clk        (Clk),
        .reset      (reset),
        .readInstr  (readInstr),
        .instrAddr  (instrAddr),
        .instrIn    (instrIn),
        .readData   (readData),
        .writeData  (writeData),
        .dataAddr   (dataAddr),
        .dataIn     (dataIn),
        .dataOut    (dataOut),
        .numInst    (numInst),
        .outputPort (outputPort),
        .halted     (halted)
    );

    cpuChecker i_check (
        .Clk        (Clk),
        .reset      (reset),
        .halted     (halted),
        .readInstr  (readInstr),
        .readData   (readData),
        .writeData  (writeData),
        .outputPort (outputPort),
        .numInst    (numInst),
        .testCount  (testCount),
        .failCount  (failCount),
        .errCount   (errCount)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    // both memories answer in the same cycle
    assign instrIn = instrMem[instrAddr[5:0]];
    // data only comes back on a read strobe
    assign dataIn = (readData === 1'b1) ? dataMem[dataAddr[7:0]] : 16'hxxxx;

    always @(posedge Clk) begin
        if (writeData === 1'b1) begin
            dataMem[dataAddr[7:0]] <= dataOut;
        end
    end

    function automatic logic [15:0] rWord(input logic [1:0] rs, input logic [1:0] rt,
                                          input logic [1:0] rd, input logic [5:0] func);
        return {opAlu, rs, rt, rd, func};
    endfunction

    function automatic logic [15:0] iWord(input logic [3:0] op, input logic [1:0] rs,
                                          input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] jWord(input logic [3:0] op, input logic [11:0] target);
        return {op, target};
    endfunction

    task automatic addWord(input int t, input logic [15:0] w);
        progs[t][progLen[t]] = w;
        progLen[t] = progLen[t] + 1;
    endtask

    task automatic buildTable();
        int t;
        for (t = 0; t < numTests; t++) begin
            progLen[t] = 0;
            loadAddr[t] = -1;
        end
        // forwarding from memory and writeback stages
        t = 0;
        names[t] = "aluChain";
        addWord(t, iWord(opAdi, 2'd0, 2'd1, 8'd5));
        addWord(t, iWord(opAdi, 2'd1, 2'd2, 8'd3));
        addWord(t, rWord(2'd1, 2'd2, 2'd3, fnAdd));
        addWord(t, rWord(2'd3, 2'd1, 2'd3, fnSub));
        addWord(t, iWord(opLhi, 2'd0, 2'd1, 8'h12));
        addWord(t, iWord(opOri, 2'd1, 2'd1, 8'h34));
        addWord(t, rWord(2'd3, 2'd1, 2'd3, fnOrr));
        addWord(t, iWord(opAdi, 2'd0, 2'd2, 8'd15));
        addWord(t, rWord(2'd3, 2'd2, 2'd2, fnAnd));
        addWord(t, rWord(2'd2, 2'd1, 2'd2, fnAdd));
        addWord(t, rWord(2'd2, 2'd0, 2'd0, fnWwd));
        addWord(t, haltWord);
        expOut[t] = 16'h1240;
        expNum[t] = 16'd12;
        // store, load back, then a load-use stall
        t = 1;
        names[t] = "storeLoad";
        addWord(t, iWord(opLhi, 2'd0, 2'd2, 8'h0A));
        addWord(t, iWord(opOri, 2'd2, 2'd2, 8'h5C));
        addWord(t, iWord(opAdi, 2'd0, 2'd1, 8'd16));
        addWord(t, iWord(opSwd, 2'd1, 2'd2, 8'd4));
        addWord(t, iWord(opLwd, 2'd1, 2'd3, 8'd4));
        addWord(t, rWord(2'd3, 2'd1, 2'd0, fnAdd));
        addWord(t, rWord(2'd0, 2'd0, 2'd0, fnWwd));
        addWord(t, haltWord);
        expOut[t] = 16'h0A6C;
        expNum[t] = 16'd8;
        t = 2;
        names[t] = "loadPrefill";
        addWord(t, iWord(opAdi, 2'd0, 2'd1, 8'h30));
        addWord(t, iWord(opLwd, 2'd1, 2'd2, 8'd7));
        addWord(t, iWord(opAdi, 2'd2, 2'd2, 8'd1));
        addWord(t, rWord(2'd2, 2'd0, 2'd0, fnWwd));
        addWord(t, haltWord);
        expOut[t] = 16'd1;
        expNum[t] = 16'd5;
        loadAddr[t] = 55;
        // words 5, 6 and 9 must never retire
        t = 3;
        names[t] = "branches";
        addWord(t, iWord(opAdi, 2'd0, 2'd1, 8'd3));
        addWord(t, iWord(opAdi, 2'd0, 2'd2, 8'd3));
        addWord(t, iWord(opBne, 2'd1, 2'd2, 8'd2));
        addWord(t, iWord(opAdi, 2'd0, 2'd3, 8'd1));
        addWord(t, iWord(opBeq, 2'd1, 2'd2, 8'd2));
        addWord(t, iWord(opAdi, 2'd3, 2'd3, 8'd16));
        addWord(t, iWord(opAdi, 2'd3, 2'd3, 8'd32));
        addWord(t, iWord(opAdi, 2'd3, 2'd3, 8'd4));
        addWord(t, iWord(opBne, 2'd3, 2'd1, 8'd1));
        addWord(t, iWord(opAdi, 2'd3, 2'd3, 8'd64));
        addWord(t, rWord(2'd3, 2'd0, 2'd0, fnWwd));
        addWord(t, haltWord);
        expOut[t] = 16'd5;
        expNum[t] = 16'd9;
        // the two words behind HLT are in flight when it retires
        t = 4;
        names[t] = "haltHold";
        addWord(t, iWord(opAdi, 2'd0, 2'd1, 8'hFE));
        addWord(t, rWord(2'd1, 2'd0, 2'd0, fnWwd));
        addWord(t, haltWord);
        addWord(t, iWord(opAdi, 2'd0, 2'd1, 8'd1));
        addWord(t, rWord(2'd1, 2'd0, 2'd0, fnWwd));
        expOut[t] = 16'hFFFE;
        expNum[t] = 16'd3;
        // JAL links 4 into r2, JPR comes back to word 4
        t = 5;
        names[t] = "jumps";
        addWord(t, iWord(opAdi, 2'd0, 2'd1, 8'd7));
        addWord(t, jWord(opJmp, 12'd3));
        addWord(t, iWord(opAdi, 2'd1, 2'd1, 8'd1));
        addWord(t, jWord(opJal, 12'd7));
        addWord(t, rWord(2'd2, 2'd0, 2'd0, fnWwd));
        addWord(t, haltWord);
        addWord(t, iWord(opAdi, 2'd1, 2'd1, 8'd8));
        addWord(t, iWord(opAdi, 2'd1, 2'd3, 8'd2));
        addWord(t, rWord(2'd2, 2'd0, 2'd0, fnJpr));
        addWord(t, iWord(opAdi, 2'd0, 2'd2, 8'd0));
        addWord(t, haltWord);
        expOut[t] = 16'd4;
        expNum[t] = 16'd7;
    endtask

    task automatic makePrefill();
        int a;
        for (a = 0; a < dmemWords; a++) begin
            prefill[a] = 16'($random(seed));
        end
    endtask

    task automatic loadMemories(input int t);
        int a;
        for (a = 0; a < imemWords; a++) begin
            if (a < progLen[t]) begin
                instrMem[a] = progs[t][a];
            end else begin
                instrMem[a] = haltWord;
            end
        end
        for (a = 0; a < dmemWords; a++) begin
            dataMem[a] <= prefill[a];
        end
    endtask

    task automatic runTest(input int t);
        logic [15:0] want;
        @(posedge Clk);
        #2;
        reset = 1'b1;
        curName = names[t];
        loadMemories(t);
        i_check.startTest(names[t]);
        repeat (4) @(posedge Clk);
        #2;
        reset = 1'b0;
        while (halted !== 1'b1) begin
            @(posedge Clk);
            #2;
        end
        // the halted state has to sit still for a while
        repeat (4) @(posedge Clk);
        #2;
        want = expOut[t];
        if (loadAddr[t] >= 0) begin
            want = want + prefill[loadAddr[t]];
        end
        i_check.checkTest(want, expNum[t]);
    endtask

    initial begin
        int t;
        reset = 1'b1;
        seed = 7;
        curName = "none";
        buildTable();
        makePrefill();
        loadMemories(0);
        for (t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("tests %0d, failed %0d, errors %0d", testCount, failCount, errCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (cycleLimit) @(posedge Clk);
        $display("timeout in %s: processor never halted within %0d cycles",
                 curName, cycleLimit);
        $display("Done: errors found");
        $finish;
    end

endmodule
